//--- source/core_config_pkg.sv
// Machine-size constants and default sizing for the rename unit, referenced by scoped name
package core_config_pkg;

    // Architectural register file, fixed by the ISA
    localparam int ARCH_REG_COUNT = 32;
    localparam int ARCH_IDX_W = 5;

    // x0 is hardwired and never renamed
    localparam logic [ARCH_IDX_W-1:0] ZERO_REG = '0;

    // Defaults picked up by the top level
    localparam int DEFAULT_PHYS_REG_COUNT = 64;
    localparam int DEFAULT_RETIRE_DEPTH = 32;

endpackage

//--- source/rename_types_pkg.sv
// Instruction word layout and opcode constants used when decoding for rename
package rename_types_pkg;

    localparam int INSTR_W = 32;

    localparam logic [6:0] OPCODE_R_TYPE = 7'b0110011;

    // Register-register format
    typedef struct packed {
        logic [6:0]                            funct7;
        logic [core_config_pkg::ARCH_IDX_W-1:0] rs2;
        logic [core_config_pkg::ARCH_IDX_W-1:0] rs1;
        logic [2:0]                            funct3;
        logic [core_config_pkg::ARCH_IDX_W-1:0] rd;
        logic [6:0]                            opcode;
    } r_type_fields_t;

    // Immediate format, same positions for rs1, rd and opcode
    typedef struct packed {
        logic [11:0]                           imm;
        logic [core_config_pkg::ARCH_IDX_W-1:0] rs1;
        logic [2:0]                            funct3;
        logic [core_config_pkg::ARCH_IDX_W-1:0] rd;
        logic [6:0]                            opcode;
    } i_type_fields_t;

    typedef union packed {
        r_type_fields_t r;
        i_type_fields_t i;
    } instr_word_u;

endpackage

//--- source/map_table.sv
// Speculative and retired register maps with ready bits, CDB forwarding and flush restore
`timescale 1ns/1ps

module map_table #(
    parameter int PHYS_REG_COUNT = 64,
    localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT),
    localparam int ARCH_IDX_W = core_config_pkg::ARCH_IDX_W
) (
    input  logic                  clk,
    input  logic                  reset,
    // Combinational reads
    input  logic [ARCH_IDX_W-1:0] rs1_idx,
    input  logic [ARCH_IDX_W-1:0] rs2_idx,
    input  logic [ARCH_IDX_W-1:0] dest_idx,
    output logic [PHYS_IDX_W-1:0] rs1_preg,
    output logic                  rs1_ready,
    output logic [PHYS_IDX_W-1:0] rs2_preg,
    output logic                  rs2_ready,
    output logic [PHYS_IDX_W-1:0] old_dest_preg,
    // New destination from the rename stage
    input  logic                  set_dest_enable,
    input  logic [PHYS_IDX_W-1:0] new_dest_preg,
    // Result broadcast
    input  logic                  cdb_valid,
    input  logic [PHYS_IDX_W-1:0] cdb_preg,
    // Commit
    input  logic                  retire_enable,
    input  logic [ARCH_IDX_W-1:0] retire_arch_reg,
    input  logic [PHYS_IDX_W-1:0] retire_preg,
    input  logic                  restore_enable
);

    localparam int ARCH_COUNT = core_config_pkg::ARCH_REG_COUNT;

    logic [PHYS_IDX_W-1:0] spec_preg [ARCH_COUNT];
    logic                  spec_ready [ARCH_COUNT];
    logic [PHYS_IDX_W-1:0] ret_preg [ARCH_COUNT];

    // Source reads return preg 0 ready for x0
    always_comb begin
        if (rs1_idx == core_config_pkg::ZERO_REG) begin
            rs1_preg = '0;
            rs1_ready = 1'b1;
        end else begin
            rs1_preg = spec_preg[rs1_idx];
            // Same-cycle broadcast counts as ready
            rs1_ready = spec_ready[rs1_idx] || (cdb_valid && (cdb_preg == spec_preg[rs1_idx]));
        end
    end

    always_comb begin
        if (rs2_idx == core_config_pkg::ZERO_REG) begin
            rs2_preg = '0;
            rs2_ready = 1'b1;
        end else begin
            rs2_preg = spec_preg[rs2_idx];
            rs2_ready = spec_ready[rs2_idx] || (cdb_valid && (cdb_preg == spec_preg[rs2_idx]));
        end
    end

    // Mapping that the new destination replaces
    always_comb begin
        if (dest_idx == core_config_pkg::ZERO_REG) begin
            old_dest_preg = '0;
        end else begin
            old_dest_preg = spec_preg[dest_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map with every entry ready
            for (int i = 0; i < ARCH_COUNT; i++) begin
                spec_preg[i] <= PHYS_IDX_W'(i);
                spec_ready[i] <= 1'b1;
                ret_preg[i] <= PHYS_IDX_W'(i);
            end
        end else begin
            if (restore_enable) begin
                // Retired values have been written back, so all of them are ready
                for (int i = 0; i < ARCH_COUNT; i++) begin
                    spec_preg[i] <= ret_preg[i];
                    spec_ready[i] <= 1'b1;
                end
            end else begin
                if (cdb_valid) begin
                    for (int i = 1; i < ARCH_COUNT; i++) begin
                        if (spec_preg[i] == cdb_preg) begin
                            spec_ready[i] <= 1'b1;
                        end
                    end
                end
                // A freshly allocated preg is never on the CDB, so this wins
                if (set_dest_enable && (dest_idx != core_config_pkg::ZERO_REG)) begin
                    spec_preg[dest_idx] <= new_dest_preg;
                    spec_ready[dest_idx] <= 1'b0;
                end
            end

            // Retired map takes the preg recorded at rename
            if (retire_enable && (retire_arch_reg != core_config_pkg::ZERO_REG)) begin
                ret_preg[retire_arch_reg] <= retire_preg;
            end
        end
    end

endmodule

//--- source/free_list.sv
// Circular queue of free physical registers, allocated at the head and released at the tail
`timescale 1ns/1ps

module free_list #(
    parameter int PHYS_REG_COUNT = 64,
    localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc_enable,
    output logic [PHYS_IDX_W-1:0] alloc_preg,
    output logic                  empty,
    input  logic                  release_enable,
    input  logic [PHYS_IDX_W-1:0] release_preg,
    input  logic                  flush
);

    localparam int ARCH_COUNT = core_config_pkg::ARCH_REG_COUNT;
    localparam int FREE_COUNT = PHYS_REG_COUNT - ARCH_COUNT;
    localparam int PTR_W = $clog2(FREE_COUNT);
    localparam int CNT_W = $clog2(FREE_COUNT + 1);

    logic [PHYS_IDX_W-1:0] entries [FREE_COUNT];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] commit_head;
    logic [CNT_W-1:0] count;

    assign alloc_preg = entries[head];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Pregs above the identity-mapped ones start out free, in order
            for (int i = 0; i < FREE_COUNT; i++) begin
                entries[i] <= PHYS_IDX_W'(ARCH_COUNT + i);
            end
            head <= '0;
            tail <= '0;
            commit_head <= '0;
            count <= CNT_W'(FREE_COUNT);
        end else if (flush) begin
            // Every retire frees one preg and commits one, so the rewound list is full
            head <= commit_head;
            count <= CNT_W'(FREE_COUNT);
        end else begin
            if (alloc_enable) begin
                head <= (head == PTR_W'(FREE_COUNT - 1)) ? '0 : head + 1'b1;
            end
            if (release_enable) begin
                entries[tail] <= release_preg;
                tail <= (tail == PTR_W'(FREE_COUNT - 1)) ? '0 : tail + 1'b1;
                // The retiring instruction's own allocation is now committed
                commit_head <= (commit_head == PTR_W'(FREE_COUNT - 1)) ? '0 : commit_head + 1'b1;
            end
            if (alloc_enable && !release_enable) begin
                count <= count - 1'b1;
            end else if (release_enable && !alloc_enable) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- source/retire_queue.sv
// In-order FIFO of renamed destinations that drives commit into the map table and free list
`timescale 1ns/1ps

module retire_queue #(
    parameter int PHYS_REG_COUNT = 64,
    parameter int RETIRE_DEPTH = 32,
    localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT),
    localparam int ARCH_IDX_W = core_config_pkg::ARCH_IDX_W
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic [ARCH_IDX_W-1:0] push_arch_rd,
    input  logic [PHYS_IDX_W-1:0] push_new_preg,
    input  logic [PHYS_IDX_W-1:0] push_old_preg,
    input  logic                  push_writes_rd,
    output logic                  full,
    input  logic                  retire_valid,
    input  logic                  flush,
    output logic                  retire_enable,
    output logic [ARCH_IDX_W-1:0] retire_arch_reg,
    output logic [PHYS_IDX_W-1:0] retire_preg,
    output logic                  release_enable,
    output logic [PHYS_IDX_W-1:0] release_preg,
    output logic                  queue_empty
);

    localparam int PTR_W = $clog2(RETIRE_DEPTH);
    localparam int CNT_W = $clog2(RETIRE_DEPTH + 1);

    logic [ARCH_IDX_W-1:0] arch_rd_mem [RETIRE_DEPTH];
    logic [PHYS_IDX_W-1:0] new_preg_mem [RETIRE_DEPTH];
    logic [PHYS_IDX_W-1:0] old_preg_mem [RETIRE_DEPTH];
    logic                  writes_rd_mem [RETIRE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic pop;

    assign full = (count == CNT_W'(RETIRE_DEPTH));
    assign queue_empty = (count == '0);

    // Flush wins over retire, an empty queue ignores retire
    assign pop = retire_valid && !queue_empty && !flush;

    assign retire_enable = pop;
    assign retire_arch_reg = arch_rd_mem[head];
    assign retire_preg = new_preg_mem[head];
    // Only a real destination hands its old preg back
    assign release_enable = pop && writes_rd_mem[head];
    assign release_preg = old_preg_mem[head];

    always_ff @(posedge clk) begin
        if (push) begin
            arch_rd_mem[tail] <= push_arch_rd;
            new_preg_mem[tail] <= push_new_preg;
            old_preg_mem[tail] <= push_old_preg;
            writes_rd_mem[tail] <= push_writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(RETIRE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(RETIRE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/rename_stage.sv
// Rename pipeline stage that decodes the word, accepts it, allocates rd and registers the result
`timescale 1ns/1ps

module rename_stage #(
    parameter int PHYS_REG_COUNT = 64,
    localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT),
    localparam int ARCH_IDX_W = core_config_pkg::ARCH_IDX_W
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid,
    input  logic [rename_types_pkg::INSTR_W-1:0] instr_word,
    output logic                                 instr_ready,
    input  logic                                 free_empty,
    input  logic                                 queue_full,
    input  logic [PHYS_IDX_W-1:0]                alloc_preg,
    output logic                                 alloc_enable,
    output logic                                 push,
    // Map table side
    output logic [ARCH_IDX_W-1:0]                rs1_idx,
    output logic [ARCH_IDX_W-1:0]                rs2_idx,
    output logic [ARCH_IDX_W-1:0]                dest_idx,
    input  logic [PHYS_IDX_W-1:0]                rs1_preg,
    input  logic                                 rs1_ready,
    input  logic [PHYS_IDX_W-1:0]                rs2_preg,
    input  logic                                 rs2_ready,
    input  logic [PHYS_IDX_W-1:0]                old_dest_preg,
    output logic                                 set_dest_enable,
    output logic [PHYS_IDX_W-1:0]                new_dest_preg,
    // Registered result
    output logic                                 renamed_valid,
    output logic [PHYS_IDX_W-1:0]                renamed_rs1_preg,
    output logic                                 renamed_rs1_ready,
    output logic [PHYS_IDX_W-1:0]                renamed_rs2_preg,
    output logic                                 renamed_rs2_ready,
    output logic [PHYS_IDX_W-1:0]                renamed_rd_preg,
    output logic [PHYS_IDX_W-1:0]                renamed_old_rd_preg,
    output logic                                 renamed_writes_rd,
    input  logic                                 flush
);

    rename_types_pkg::instr_word_u word;
    logic is_r_type;
    logic writes_rd;
    logic accept;

    assign word = instr_word;
    assign is_r_type = (word.i.opcode == rename_types_pkg::OPCODE_R_TYPE);

    assign rs1_idx = word.i.rs1;
    assign dest_idx = word.i.rd;
    // I-type has no rs2, reading x0 gives preg 0 ready
    assign rs2_idx = is_r_type ? word.r.rs2 : core_config_pkg::ZERO_REG;

    assign writes_rd = (dest_idx != core_config_pkg::ZERO_REG);

    // Flush edges drop renames, so hold the instruction off
    assign instr_ready = !queue_full && !(writes_rd && free_empty) && !flush;
    assign accept = instr_valid && instr_ready;

    assign alloc_enable = accept && writes_rd;
    assign set_dest_enable = accept && writes_rd;
    assign new_dest_preg = alloc_preg;
    assign push = accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            renamed_valid <= 1'b0;
        end else begin
            renamed_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            renamed_rs1_preg <= rs1_preg;
            renamed_rs1_ready <= rs1_ready;
            renamed_rs2_preg <= rs2_preg;
            renamed_rs2_ready <= rs2_ready;
            renamed_rd_preg <= writes_rd ? alloc_preg : '0;
            renamed_old_rd_preg <= old_dest_preg;
            renamed_writes_rd <= writes_rd;
        end
    end

endmodule

//--- source/rename_unit.sv
// Rename unit top level that wires the stage to the map table, free list and retire queue
`timescale 1ns/1ps

module rename_unit #(
    parameter int PHYS_REG_COUNT = core_config_pkg::DEFAULT_PHYS_REG_COUNT,
    parameter int RETIRE_DEPTH = core_config_pkg::DEFAULT_RETIRE_DEPTH,
    localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT)
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid,
    input  logic [rename_types_pkg::INSTR_W-1:0] instr_word,
    output logic                                 instr_ready,
    input  logic                                 cdb_valid,
    input  logic [PHYS_IDX_W-1:0]                cdb_preg,
    input  logic                                 retire_valid,
    input  logic                                 flush,
    output logic                                 renamed_valid,
    output logic [PHYS_IDX_W-1:0]                renamed_rs1_preg,
    output logic                                 renamed_rs1_ready,
    output logic [PHYS_IDX_W-1:0]                renamed_rs2_preg,
    output logic                                 renamed_rs2_ready,
    output logic [PHYS_IDX_W-1:0]                renamed_rd_preg,
    output logic [PHYS_IDX_W-1:0]                renamed_old_rd_preg,
    output logic                                 renamed_writes_rd
);

    localparam int ARCH_IDX_W = core_config_pkg::ARCH_IDX_W;

    logic [ARCH_IDX_W-1:0] rs1_idx;
    logic [ARCH_IDX_W-1:0] rs2_idx;
    logic [ARCH_IDX_W-1:0] dest_idx;
    logic [PHYS_IDX_W-1:0] rs1_preg;
    logic                  rs1_ready;
    logic [PHYS_IDX_W-1:0] rs2_preg;
    logic                  rs2_ready;
    logic [PHYS_IDX_W-1:0] old_dest_preg;
    logic                  set_dest_enable;
    logic [PHYS_IDX_W-1:0] new_dest_preg;
    logic                  alloc_enable;
    logic [PHYS_IDX_W-1:0] alloc_preg;
    logic                  free_empty;
    logic                  push;
    logic                  queue_full;
    logic                  queue_empty;
    logic                  retire_enable;
    logic [ARCH_IDX_W-1:0] retire_arch_reg;
    logic [PHYS_IDX_W-1:0] retire_preg;
    logic                  release_enable;
    logic [PHYS_IDX_W-1:0] release_preg;

    rename_stage #(.PHYS_REG_COUNT(PHYS_REG_COUNT)) rename_stage_i (
        .clk, .reset, .instr_valid, .instr_word, .instr_ready,
        .free_empty, .queue_full, .alloc_preg, .alloc_enable, .push,
        .rs1_idx, .rs2_idx, .dest_idx, .rs1_preg, .rs1_ready, .rs2_preg, .rs2_ready,
        .old_dest_preg, .set_dest_enable, .new_dest_preg,
        .renamed_valid, .renamed_rs1_preg, .renamed_rs1_ready,
        .renamed_rs2_preg, .renamed_rs2_ready, .renamed_rd_preg,
        .renamed_old_rd_preg, .renamed_writes_rd, .flush
    );

    map_table #(.PHYS_REG_COUNT(PHYS_REG_COUNT)) map_table_i (
        .clk, .reset, .rs1_idx, .rs2_idx, .dest_idx,
        .rs1_preg, .rs1_ready, .rs2_preg, .rs2_ready, .old_dest_preg,
        .set_dest_enable, .new_dest_preg, .cdb_valid, .cdb_preg,
        .retire_enable, .retire_arch_reg, .retire_preg,
        .restore_enable(flush)
    );

    free_list #(.PHYS_REG_COUNT(PHYS_REG_COUNT)) free_list_i (
        .clk, .reset, .alloc_enable, .alloc_preg, .empty(free_empty),
        .release_enable, .release_preg, .flush
    );

    // While push is high, set_dest_enable is exactly the writes-rd flag
    retire_queue #(
        .PHYS_REG_COUNT(PHYS_REG_COUNT),
        .RETIRE_DEPTH(RETIRE_DEPTH)
    ) retire_queue_i (
        .clk, .reset, .push,
        .push_arch_rd(dest_idx),
        .push_new_preg(new_dest_preg),
        .push_old_preg(old_dest_preg),
        .push_writes_rd(set_dest_enable),
        .full(queue_full), .retire_valid, .flush,
        .retire_enable, .retire_arch_reg, .retire_preg,
        .release_enable, .release_preg, .queue_empty
    );

endmodule

//--- test/rename_unit_checker.sv
// Concurrent assertions on the rename unit handshake and commit rules, bound into rename_unit
`timescale 1ns/1ps

module rename_unit_checker #(
    parameter int PHYS_IDX_W = 6
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  instr_valid,
    input logic                  instr_ready,
    input logic                  renamed_valid,
    input logic                  retire_valid,
    input logic                  queue_empty,
    input logic                  flush,
    input logic                  renamed_writes_rd,
    input logic [PHYS_IDX_W-1:0] renamed_rd_preg
);

    // Number of assertion failures so far
    int failure_count = 0;

    // Result register follows an accept by exactly one cycle
    accept_gives_valid: assert property (@(posedge clk) disable iff (reset)
        (instr_valid && instr_ready) |=> renamed_valid)
        else begin
            failure_count++;
            $error("renamed_valid did not follow an accepted instruction");
        end

    valid_needs_accept: assert property (@(posedge clk) disable iff (reset)
        renamed_valid |-> $past(instr_valid && instr_ready))
        else begin
            failure_count++;
            $error("renamed_valid rose without an accept in the previous cycle");
        end

    retire_needs_entry: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !queue_empty)
        else begin
            failure_count++;
            $error("retire_valid raised while the retire queue was empty");
        end

    flush_excludes_retire: assert property (@(posedge clk) disable iff (reset)
        !(flush && retire_valid))
        else begin
            failure_count++;
            $error("flush and retire_valid were high in the same cycle");
        end

    // A real destination never gets preg 0
    written_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        (renamed_valid && renamed_writes_rd) |-> (renamed_rd_preg != '0))
        else begin
            failure_count++;
            $error("renamed_rd_preg is zero for an instruction that writes rd");
        end

endmodule

bind rename_unit rename_unit_checker #(.PHYS_IDX_W(PHYS_IDX_W)) rename_unit_checker_i (
    .clk, .reset, .instr_valid, .instr_ready, .renamed_valid, .retire_valid,
    .queue_empty, .flush, .renamed_writes_rd, .renamed_rd_preg
);

//--- test/tb_rename_unit.sv
// Directed testbench that checks every result of the rename unit against a reference model
`timescale 1ns/1ps

module tb_rename_unit;

    localparam int ARCH = core_config_pkg::ARCH_REG_COUNT;
    localparam int PHYS = core_config_pkg::DEFAULT_PHYS_REG_COUNT;
    localparam int PHYS_IDX_W = $clog2(PHYS);
    localparam int WAIT_LIMIT = 40;

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    logic [31:0]           instr_word;
    logic                  instr_ready;
    logic                  cdb_valid;
    logic [PHYS_IDX_W-1:0] cdb_preg;
    logic                  retire_valid;
    logic                  flush;
    logic                  renamed_valid;
    logic [PHYS_IDX_W-1:0] renamed_rs1_preg;
    logic                  renamed_rs1_ready;
    logic [PHYS_IDX_W-1:0] renamed_rs2_preg;
    logic                  renamed_rs2_ready;
    logic [PHYS_IDX_W-1:0] renamed_rd_preg;
    logic [PHYS_IDX_W-1:0] renamed_old_rd_preg;
    logic                  renamed_writes_rd;

    // Reference model of the maps, free list order and retire queue
    int spec_map [ARCH];
    bit spec_rdy [ARCH];
    int ret_map [ARCH];
    int free_q [$];
    int inflight_q [$];
    int rq_arch [$];
    int rq_new [$];
    int rq_old [$];
    logic [31:0] rng_state;

    rename_unit dut_i (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0d, actual %0d", what, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int random_index(input int range);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % range);
    endfunction

    function automatic logic [31:0] make_r_type(input int rs1, input int rs2, input int rd);
        rename_types_pkg::instr_word_u w;
        w = '0;
        w.r.rs2 = 5'(rs2);
        w.r.rs1 = 5'(rs1);
        w.r.rd = 5'(rd);
        w.r.opcode = rename_types_pkg::OPCODE_R_TYPE;
        return w;
    endfunction

    function automatic logic [31:0] make_i_type(input int rs1, input int rd);
        rename_types_pkg::instr_word_u w;
        w = '0;
        w.i.imm = 12'h04;
        w.i.rs1 = 5'(rs1);
        w.i.rd = 5'(rd);
        // addi
        w.i.opcode = 7'b0010011;
        return w;
    endfunction

    // x0 reads as preg 0 ready, a matching broadcast in the same cycle counts as ready
    function automatic bit model_ready(input int arch, input bit cdb_on, input int cdb_p);
        if (arch == 0) begin
            return 1'b1;
        end
        return spec_rdy[arch] || (cdb_on && (cdb_p == spec_map[arch]));
    endfunction

    function automatic void apply_cdb(input int preg);
        for (int i = 1; i < ARCH; i++) begin
            if (spec_map[i] == preg) begin
                spec_rdy[i] = 1'b1;
            end
        end
    endfunction

    task automatic rename_and_check(input string name, input bit is_r, input int rs1,
                                    input int rs2, input int rd, input bit cdb_on,
                                    input int cdb_p);
        int exp_rs1;
        int exp_rs2;
        int exp_rd;
        int exp_old;
        bit exp_rs1_rdy;
        bit exp_rs2_rdy;
        int waited;
        exp_rs1 = (rs1 == 0) ? 0 : spec_map[rs1];
        exp_rs2 = (is_r && rs2 != 0) ? spec_map[rs2] : 0;
        exp_rs1_rdy = model_ready(rs1, cdb_on, cdb_p);
        exp_rs2_rdy = is_r ? model_ready(rs2, cdb_on, cdb_p) : 1'b1;
        exp_rd = (rd != 0) ? free_q[0] : 0;
        exp_old = (rd != 0) ? spec_map[rd] : 0;
        instr_valid = 1'b1;
        instr_word = is_r ? make_r_type(rs1, rs2, rd) : make_i_type(rs1, rd);
        cdb_valid = cdb_on;
        cdb_preg = PHYS_IDX_W'(cdb_p);
        waited = 0;
        #1;
        while (!instr_ready) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout({name, ": instr_ready never went high"});
            end
            @(negedge clk);
            #1;
            waited++;
        end
        @(posedge clk);
        @(negedge clk);
        instr_valid = 1'b0;
        cdb_valid = 1'b0;
        waited = 0;
        while (!renamed_valid) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout({name, ": renamed_valid never rose after an accept"});
            end
            @(negedge clk);
            waited++;
        end
        check_value({name, " rs1_preg"}, exp_rs1, renamed_rs1_preg);
        check_value({name, " rs1_ready"}, exp_rs1_rdy, renamed_rs1_ready);
        check_value({name, " rs2_preg"}, exp_rs2, renamed_rs2_preg);
        check_value({name, " rs2_ready"}, exp_rs2_rdy, renamed_rs2_ready);
        check_value({name, " rd_preg"}, exp_rd, renamed_rd_preg);
        check_value({name, " old_rd_preg"}, exp_old, renamed_old_rd_preg);
        check_value({name, " writes_rd"}, rd != 0, renamed_writes_rd);
        if (cdb_on) begin
            apply_cdb(cdb_p);
        end
        if (rd != 0) begin
            void'(free_q.pop_front());
            inflight_q.push_back(exp_rd);
            spec_map[rd] = exp_rd;
            spec_rdy[rd] = 1'b0;
        end
        rq_arch.push_back(rd);
        rq_new.push_back(exp_rd);
        rq_old.push_back(exp_old);
    endtask

    task automatic broadcast_cdb(input int preg);
        cdb_valid = 1'b1;
        cdb_preg = PHYS_IDX_W'(preg);
        @(posedge clk);
        @(negedge clk);
        cdb_valid = 1'b0;
        apply_cdb(preg);
    endtask

    task automatic retire_oldest();
        int arch;
        int new_preg;
        int old_preg;
        retire_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        retire_valid = 1'b0;
        arch = rq_arch.pop_front();
        new_preg = rq_new.pop_front();
        old_preg = rq_old.pop_front();
        // Only a real destination commits and frees its old preg
        if (arch != 0) begin
            ret_map[arch] = new_preg;
            void'(inflight_q.pop_front());
            free_q.push_back(old_preg);
        end
    endtask

    task automatic flush_pipeline();
        flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < ARCH; i++) begin
            spec_map[i] = ret_map[i];
            spec_rdy[i] = 1'b1;
        end
        // Speculative allocations go back in front in their original order
        while (inflight_q.size() > 0) begin
            free_q.push_front(inflight_q.pop_back());
        end
        rq_arch.delete();
        rq_new.delete();
        rq_old.delete();
    endtask

    task automatic test_reset_identity();
        rename_and_check("reset_identity", 1'b0, 5, 0, 7, 1'b0, 0);
        check_value("reset_identity rd_preg", 32, renamed_rd_preg);
        check_value("reset_identity old_rd_preg", 7, renamed_old_rd_preg);
    endtask

    task automatic test_cdb_forwarding();
        rename_and_check("cdb_forwarding", 1'b1, 7, 5, 8, 1'b0, 0);
        check_value("cdb_forwarding pending", 0, renamed_rs1_ready);
        rename_and_check("cdb_forwarding", 1'b1, 7, 0, 9, 1'b1, 32);
        check_value("cdb_forwarding same cycle", 1, renamed_rs1_ready);
        broadcast_cdb(spec_map[8]);
        rename_and_check("cdb_forwarding", 1'b1, 8, 7, 11, 1'b0, 0);
        check_value("cdb_forwarding stored", 1, renamed_rs1_ready);
    endtask

    task automatic test_zero_dest();
        rename_and_check("zero_dest", 1'b0, 0, 0, 0, 1'b0, 0);
        rename_and_check("zero_dest", 1'b1, 0, 9, 10, 1'b0, 0);
    endtask

    task automatic test_free_list_full();
        int rd;
        int released;
        while (rq_arch.size() > 0) begin
            retire_oldest();
        end
        repeat (32) begin
            rd = 1 + random_index(31);
            rename_and_check("free_list_full", 1'b1, random_index(32), random_index(32), rd,
                             1'b0, 0);
        end
        rd = 1 + random_index(31);
        instr_valid = 1'b1;
        instr_word = make_r_type(3, 4, rd);
        #1;
        check_value("free_list_full instr_ready", 0, instr_ready);
        @(negedge clk);
        released = rq_old[0];
        retire_oldest();
        #1;
        check_value("free_list_full instr_ready after retire", 1, instr_ready);
        rename_and_check("free_list_full", 1'b1, 3, 4, rd, 1'b0, 0);
        check_value("free_list_full reused preg", released, renamed_rd_preg);
    endtask

    task automatic test_flush_restore();
        repeat (3) retire_oldest();
        repeat (2) begin
            rename_and_check("flush_restore", 1'b1, random_index(32), random_index(32),
                             1 + random_index(31), 1'b0, 0);
        end
        broadcast_cdb(inflight_q[inflight_q.size() - 1]);
        flush_pipeline();
        // Read every register through rd = 0 so nothing is allocated
        for (int i = 0; i < ARCH; i += 2) begin
            rename_and_check("flush_restore", 1'b1, i, i + 1, 0, 1'b0, 0);
            check_value("flush_restore rs1_ready", 1, renamed_rs1_ready);
            check_value("flush_restore rs2_ready", 1, renamed_rs2_ready);
        end
        rename_and_check("flush_restore", 1'b1, 1, 2, 3, 1'b0, 0);
    endtask

    initial begin
        rng_state = 32'h81a39455;
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_word = '0;
        cdb_valid = 1'b0;
        cdb_preg = '0;
        retire_valid = 1'b0;
        flush = 1'b0;
        for (int i = 0; i < ARCH; i++) begin
            spec_map[i] = i;
            spec_rdy[i] = 1'b1;
            ret_map[i] = i;
        end
        for (int p = ARCH; p < PHYS; p++) begin
            free_q.push_back(p);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_identity();
        test_cdb_forwarding();
        test_zero_dest();
        test_free_list_full();
        test_flush_restore();
        if (dut_i.rename_unit_checker_i.failure_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

//--- filelist.f
source/core_config_pkg.sv
source/rename_types_pkg.sv
source/map_table.sv
source/free_list.sv
source/retire_queue.sv
source/rename_stage.sv
source/rename_unit.sv
test/rename_unit_checker.sv
test/tb_rename_unit.sv
